// ==== exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define OPCODE_W    17              // major[16:10], funct3[9:7], funct7[6:0]
`define SHAMT_W     5

// RV32I major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011

`define FUNCT7_BASE 7'b0000000
`define FUNCT7_ALT  7'b0100000      // sub, sra, srai

`define STRB_BYTE   4'b0001
`define STRB_HALF   4'b0011
`define STRB_WORD   4'b1111

`define PC_STEP     32'd4

`endif

// ==== exec_pkg.sv ====
`include "exec_consts.svh"

package exec_pkg;

    typedef enum logic [5:0] {
        OP_NONE = 6'd0,
        OP_ADD, OP_ADDI, OP_SUB,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI,
        OP_SLL, OP_SLLI, OP_SRL, OP_SRLI, OP_SRA, OP_SRAI,
        OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } op_e;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        op_e                    op;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1_data;
        logic [`XLEN-1:0]       rs2_data;
        logic [`XLEN-1:0]       imm;
    } ex_in_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
    } reg_wr_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       addr;
        logic [3:0]             strb;
        logic                   is_signed;
    } mem_rd_t;

    typedef struct packed {
        logic                   en;
        logic [`XLEN-1:0]       addr;
        logic [3:0]             strb;
        logic [`XLEN-1:0]       data;
    } mem_wr_t;

    typedef struct packed {
        logic                   taken;
        logic [`XLEN-1:0]       target;
    } jump_t;

endpackage

// ==== exec_decode.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_decode import exec_pkg::*; (
    input  logic [`OPCODE_W-1:0] opcode,
    output op_e                  op
);

    logic [6:0] major;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f7_base;
    logic       f7_alt;

    assign major   = opcode[`OPCODE_W-1 -: 7];
    assign funct3  = opcode[9:7];
    assign funct7  = opcode[6:0];
    assign f7_base = (funct7 == `FUNCT7_BASE);
    assign f7_alt  = (funct7 == `FUNCT7_ALT);

    always_comb begin
        op = OP_NONE;
        case (major)
            `OPC_OP: begin
                case (funct3)
                    3'b000:  op = f7_base ? OP_ADD : (f7_alt ? OP_SUB : OP_NONE);
                    3'b001:  op = f7_base ? OP_SLL : OP_NONE;
                    3'b010:  op = f7_base ? OP_SLT : OP_NONE;
                    3'b011:  op = f7_base ? OP_SLTU : OP_NONE;
                    3'b100:  op = f7_base ? OP_XOR : OP_NONE;
                    3'b101:  op = f7_base ? OP_SRL : (f7_alt ? OP_SRA : OP_NONE);
                    3'b110:  op = f7_base ? OP_OR : OP_NONE;
                    default: op = f7_base ? OP_AND : OP_NONE;
                endcase
            end
            `OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  op = OP_ADDI;
                    3'b001:  op = f7_base ? OP_SLLI : OP_NONE;  // shamt form only
                    3'b010:  op = OP_SLTI;
                    3'b011:  op = OP_SLTIU;
                    3'b100:  op = OP_XORI;
                    3'b101:  op = f7_base ? OP_SRLI : (f7_alt ? OP_SRAI : OP_NONE);
                    3'b110:  op = OP_ORI;
                    default: op = OP_ANDI;
                endcase
            end
            `OPC_LUI:   op = OP_LUI;
            `OPC_AUIPC: op = OP_AUIPC;
            `OPC_JAL:   op = OP_JAL;
            `OPC_JALR:  op = (funct3 == 3'b000) ? OP_JALR : OP_NONE;
            `OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = OP_LB;
                    3'b001:  op = OP_LH;
                    3'b010:  op = OP_LW;
                    3'b100:  op = OP_LBU;
                    3'b101:  op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            `OPC_STORE: begin
                case (funct3)
                    3'b000:  op = OP_SB;
                    3'b001:  op = OP_SH;
                    3'b010:  op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = OP_BEQ;
                    3'b001:  op = OP_BNE;
                    3'b100:  op = OP_BLT;
                    3'b101:  op = OP_BGE;
                    3'b110:  op = OP_BLTU;
                    3'b111:  op = OP_BGEU;
                    default: op = OP_NONE;
                endcase
            end
            default: op = OP_NONE;
        endcase
    end

endmodule

// ==== exec_pipe_reg.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_pipe_reg import exec_pkg::*; (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   mmu_wait,
    input  logic                   allow,
    input  op_e                    op,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  logic [`XLEN-1:0]       imm,
    output ex_in_t                 q
);

    ex_in_t d;

    always_comb begin
        d          = '0;                // empty slot unless allowed
        if (allow) begin
            d.valid    = 1'b1;
            d.pc       = pc;
            d.op       = op;
            d.rd       = rd_addr;
            d.rs1_data = rs1_data;
            d.rs2_data = rs2_data;
            d.imm      = imm;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            q <= '0;
        end else if (mmu_wait) begin
            q <= q;                     // hold for memory
        end else if (stall) begin
            q <= '0;                    // bubble
        end else begin
            q <= d;
        end
    end

endmodule

// ==== exec_alu.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_alu import exec_pkg::*; (
    input  ex_in_t  ex,
    output reg_wr_t reg_wr
);

    logic [`XLEN-1:0]    imm_i;
    logic [`XLEN-1:0]    imm_u;
    logic [`XLEN-1:0]    link;
    logic [`SHAMT_W-1:0] sh_r;
    logic [`SHAMT_W-1:0] sh_i;
    logic                lt_s;
    logic                lt_u;
    logic                lti_s;
    logic                lti_u;
    logic [`XLEN-1:0]    res;
    logic                hit;

    assign imm_i = {{(`XLEN-12){ex.imm[11]}}, ex.imm[11:0]};
    assign imm_u = {ex.imm[`XLEN-1:12], 12'b0};
    assign link  = ex.pc + `PC_STEP;
    assign sh_r  = ex.rs2_data[`SHAMT_W-1:0];
    assign sh_i  = ex.imm[`SHAMT_W-1:0];
    assign lt_s  = $signed(ex.rs1_data) < $signed(ex.rs2_data);
    assign lt_u  = ex.rs1_data < ex.rs2_data;
    assign lti_s = $signed(ex.rs1_data) < $signed(imm_i);
    assign lti_u = ex.rs1_data < imm_i;

    always_comb begin
        res = '0;
        hit = 1'b1;
        case (ex.op)
            OP_ADD:   res = ex.rs1_data + ex.rs2_data;
            OP_ADDI:  res = ex.rs1_data + imm_i;
            OP_SUB:   res = ex.rs1_data - ex.rs2_data;
            OP_AND:   res = ex.rs1_data & ex.rs2_data;
            OP_ANDI:  res = ex.rs1_data & imm_i;
            OP_OR:    res = ex.rs1_data | ex.rs2_data;
            OP_ORI:   res = ex.rs1_data | imm_i;
            OP_XOR:   res = ex.rs1_data ^ ex.rs2_data;
            OP_XORI:  res = ex.rs1_data ^ imm_i;
            OP_SLL:   res = ex.rs1_data << sh_r;
            OP_SLLI:  res = ex.rs1_data << sh_i;
            OP_SRL:   res = ex.rs1_data >> sh_r;
            OP_SRLI:  res = ex.rs1_data >> sh_i;
            OP_SRA:   res = $unsigned($signed(ex.rs1_data) >>> sh_r);
            OP_SRAI:  res = $unsigned($signed(ex.rs1_data) >>> sh_i);
            OP_SLT:   res = {{(`XLEN-1){1'b0}}, lt_s};
            OP_SLTU:  res = {{(`XLEN-1){1'b0}}, lt_u};
            OP_SLTI:  res = {{(`XLEN-1){1'b0}}, lti_s};
            OP_SLTIU: res = {{(`XLEN-1){1'b0}}, lti_u};  // imm sign-extended first
            OP_LUI:   res = imm_u;
            OP_AUIPC: res = ex.pc + imm_u;
            OP_JAL,
            OP_JALR:  res = link;       // return address
            default:  hit = 1'b0;
        endcase
    end

    assign reg_wr = hit ? reg_wr_t'{en: 1'b1, rd: ex.rd, data: res} : '0;

endmodule

// ==== exec_branch.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_branch import exec_pkg::*; (
    input  ex_in_t ex,
    output jump_t  jump
);

    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] pc_target;
    logic [`XLEN-1:0] reg_sum;
    logic             eq;
    logic             lt_s;
    logic             lt_u;

    assign imm_b     = {{(`XLEN-13){ex.imm[12]}}, ex.imm[12:1], 1'b0};
    assign imm_i     = {{(`XLEN-12){ex.imm[11]}}, ex.imm[11:0]};
    assign pc_target = ex.pc + imm_b;
    assign reg_sum   = ex.rs1_data + imm_i;
    assign eq        = ex.rs1_data == ex.rs2_data;
    assign lt_s      = $signed(ex.rs1_data) < $signed(ex.rs2_data);
    assign lt_u      = ex.rs1_data < ex.rs2_data;

    always_comb begin
        jump = '0;
        case (ex.op)
            OP_BEQ:  jump = '{taken: eq, target: pc_target};
            OP_BNE:  jump = '{taken: !eq, target: pc_target};
            OP_BLT:  jump = '{taken: lt_s, target: pc_target};
            OP_BGE:  jump = '{taken: !lt_s, target: pc_target};
            OP_BLTU: jump = '{taken: lt_u, target: pc_target};
            OP_BGEU: jump = '{taken: !lt_u, target: pc_target};
            OP_JAL:  jump = '{taken: 1'b1, target: pc_target};
            OP_JALR: jump = '{taken: 1'b1, target: {reg_sum[`XLEN-1:1], 1'b0}};
            default: jump = '0;
        endcase
    end

endmodule

// ==== exec_mem_req.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_mem_req import exec_pkg::*; (
    input  ex_in_t  ex,
    output mem_rd_t mem_rd,
    output mem_wr_t mem_wr
);

    logic [`XLEN-1:0] eff_addr;

    assign eff_addr = ex.rs1_data + {{(`XLEN-12){ex.imm[11]}}, ex.imm[11:0]};

    // loads
    always_comb begin
        mem_rd = '0;
        case (ex.op)
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                mem_rd.en        = 1'b1;
                mem_rd.rd        = ex.rd;
                mem_rd.addr      = eff_addr;
                mem_rd.is_signed = (ex.op == OP_LB) || (ex.op == OP_LH);
                case (ex.op)
                    OP_LB, OP_LBU: mem_rd.strb = `STRB_BYTE;
                    OP_LH, OP_LHU: mem_rd.strb = `STRB_HALF;
                    default:       mem_rd.strb = `STRB_WORD;
                endcase
            end
            default: mem_rd = '0;
        endcase
    end

    // stores
    always_comb begin
        mem_wr = '0;
        case (ex.op)
            OP_SB, OP_SH, OP_SW: begin
                mem_wr.en   = 1'b1;
                mem_wr.addr = eff_addr;
                mem_wr.data = ex.rs2_data;  // lanes picked by strb
                case (ex.op)
                    OP_SB:   mem_wr.strb = `STRB_BYTE;
                    OP_SH:   mem_wr.strb = `STRB_HALF;
                    default: mem_wr.strb = `STRB_WORD;
                endcase
            end
            default: mem_wr = '0;
        endcase
    end

endmodule

// ==== exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module exec_stage import exec_pkg::*; (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   mmu_wait,
    input  logic                   allow,
    input  logic [`XLEN-1:0]       pc,
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  logic [`XLEN-1:0]       rs1_data,
    input  logic [`XLEN-1:0]       rs2_data,
    input  logic [`XLEN-1:0]       imm,
    output logic                   valid,
    output logic [`XLEN-1:0]       exec_pc,
    output reg_wr_t                reg_wr,
    output mem_rd_t                mem_rd,
    output mem_wr_t                mem_wr,
    output jump_t                  jump
);

    op_e    dec_op;
    ex_in_t ex_q;

    exec_decode i_decode (
        .opcode (opcode),
        .op     (dec_op)
    );

    exec_pipe_reg i_pipe_reg (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .flush    (flush),
        .stall    (stall),
        .mmu_wait (mmu_wait),
        .allow    (allow),
        .op       (dec_op),
        .pc       (pc),
        .rd_addr  (rd_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .q        (ex_q)
    );

    // three result units share the registered item
    exec_alu i_alu (
        .ex     (ex_q),
        .reg_wr (reg_wr)
    );

    exec_branch i_branch (
        .ex   (ex_q),
        .jump (jump)
    );

    exec_mem_req i_mem_req (
        .ex     (ex_q),
        .mem_rd (mem_rd),
        .mem_wr (mem_wr)
    );

    assign valid   = ex_q.valid;
    assign exec_pc = ex_q.pc;

endmodule

// ==== exec_asserts.sv ====
`timescale 1ns/1ps

module exec_asserts import exec_pkg::*; (
    input logic    CLK,
    input logic    rst_n,
    input logic    valid,
    input reg_wr_t reg_wr,
    input mem_rd_t mem_rd,
    input mem_wr_t mem_wr,
    input jump_t   jump
);

    empty_slot_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
        !valid |-> !(reg_wr.en || mem_rd.en || mem_wr.en || jump.taken))
        else $error("enable or taken high while valid is low");

    load_store_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
        !(mem_rd.en && mem_wr.en))
        else $error("load and store requested together");

    empty_after_reset: assert property (@(posedge CLK)
        $rose(rst_n) |-> !valid)
        else $error("valid high right after reset release");

endmodule

bind exec_stage exec_asserts i_asserts (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .valid  (valid),
    .reg_wr (reg_wr),
    .mem_rd (mem_rd),
    .mem_wr (mem_wr),
    .jump   (jump)
);

// ==== tb_exec_stage.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module tb_exec_stage import exec_pkg::*; ();

    localparam int PERIOD     = 100;
    localparam int NUM_CYCLES = 4000;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 2 + 20) * PERIOD;
    localparam int SEED       = 38433;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`OPCODE_W-1:0]   opc;      // raw field for the model's own decode
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       rs1;
        logic [`XLEN-1:0]       rs2;
        logic [`XLEN-1:0]       imm;
    } slot_t;

    logic                   CLK;
    logic                   rst_n;
    logic                   flush;
    logic                   stall;
    logic                   mmu_wait;
    logic                   allow;
    logic [`XLEN-1:0]       pc;
    logic [`OPCODE_W-1:0]   opcode;
    logic [`REG_ADDR_W-1:0] rd_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
    logic                   valid;
    logic [`XLEN-1:0]       exec_pc;
    reg_wr_t                reg_wr;
    mem_rd_t                mem_rd;
    mem_wr_t                mem_wr;
    jump_t                  jump;

    slot_t      m;
    reg_wr_t    e_reg;
    mem_rd_t    e_rd;
    mem_wr_t    e_wr;
    jump_t      e_jmp;
    logic       checking = 1'b0;
    int         errors = 0;
    int         checks = 0;
    logic [6:0] majors [0:8] = '{`OPC_OP, `OPC_OP_IMM, `OPC_LUI, `OPC_AUIPC, `OPC_JAL,
                                 `OPC_JALR, `OPC_LOAD, `OPC_STORE, `OPC_BRANCH};

    exec_stage i_exec_stage (.*);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic is_legal(logic [`OPCODE_W-1:0] opc);
        logic [6:0] maj;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       f7_ok;
        maj   = opc[16:10];
        f3    = opc[9:7];
        f7    = opc[6:0];
        f7_ok = (f7 == 7'd0) || (f7 == `FUNCT7_ALT && (f3 == 3'd0 || f3 == 3'd5));
        case (maj)
            `OPC_OP:                       return f7_ok;
            `OPC_OP_IMM:                   return (f3 == 3'd1 || f3 == 3'd5) ? f7_ok : 1'b1;
            `OPC_LUI, `OPC_AUIPC, `OPC_JAL: return 1'b1;
            `OPC_JALR:                     return f3 == 3'd0;
            `OPC_LOAD:                     return f3 != 3'd3 && f3 < 3'd6;
            `OPC_STORE:                    return f3 <= 3'd2;
            `OPC_BRANCH:                   return f3 != 3'd2 && f3 != 3'd3;
            default:                       return 1'b0;
        endcase
    endfunction

    function automatic logic [3:0] lane_strobe(logic [1:0] size);
        case (size)
            2'd0:    return `STRB_BYTE;
            2'd1:    return `STRB_HALF;
            default: return `STRB_WORD;
        endcase
    endfunction

    task automatic model_outputs();
        logic [6:0]         maj;
        logic [2:0]         f3;
        logic               alt;
        logic [31:0]        sext_i;
        logic [31:0]        sext_b;
        logic [31:0]        upper;
        logic [31:0]        b;
        logic signed [31:0] sra_v;
        maj    = m.opc[16:10];
        f3     = m.opc[9:7];
        alt    = m.opc[6:0] == `FUNCT7_ALT;
        sext_i = {{20{m.imm[11]}}, m.imm[11:0]};
        sext_b = {{19{m.imm[12]}}, m.imm[12:1], 1'b0};
        upper  = {m.imm[31:12], 12'h000};
        b      = (maj == `OPC_OP) ? m.rs2 : sext_i;   // second ALU operand
        sra_v  = $signed(m.rs1) >>> b[4:0];
        e_reg  = '0;
        e_rd   = '0;
        e_wr   = '0;
        e_jmp  = '0;
        if (!m.valid || !is_legal(m.opc)) begin
            return;
        end
        case (maj)
            `OPC_OP, `OPC_OP_IMM: begin
                e_reg.en = 1'b1;
                e_reg.rd = m.rd;
                case (f3)
                    3'd0:    e_reg.data = (alt && maj == `OPC_OP) ? m.rs1 - b : m.rs1 + b;
                    3'd1:    e_reg.data = m.rs1 << b[4:0];
                    3'd2:    e_reg.data = {31'b0, $signed(m.rs1) < $signed(b)};
                    3'd3:    e_reg.data = {31'b0, m.rs1 < b};
                    3'd4:    e_reg.data = m.rs1 ^ b;
                    3'd5:    e_reg.data = alt ? sra_v : m.rs1 >> b[4:0];
                    3'd6:    e_reg.data = m.rs1 | b;
                    default: e_reg.data = m.rs1 & b;
                endcase
            end
            `OPC_LUI:   e_reg = '{en: 1'b1, rd: m.rd, data: upper};
            `OPC_AUIPC: e_reg = '{en: 1'b1, rd: m.rd, data: m.pc + upper};
            `OPC_JAL, `OPC_JALR: begin
                e_reg        = '{en: 1'b1, rd: m.rd, data: m.pc + `PC_STEP};
                e_jmp.taken  = 1'b1;
                e_jmp.target = (maj == `OPC_JAL) ? m.pc + sext_b : (m.rs1 + sext_i) & ~32'd1;
            end
            `OPC_LOAD: begin
                e_rd = '{en: 1'b1, rd: m.rd, addr: m.rs1 + sext_i, strb: lane_strobe(f3[1:0]),
                         is_signed: !f3[2] && f3[1:0] != 2'd2};
            end
            `OPC_STORE: begin
                e_wr = '{en: 1'b1, addr: m.rs1 + sext_i, strb: lane_strobe(f3[1:0]),
                         data: m.rs2};
            end
            default: begin                              // branches
                e_jmp.target = m.pc + sext_b;
                case (f3)
                    3'd0:    e_jmp.taken = m.rs1 == m.rs2;
                    3'd1:    e_jmp.taken = m.rs1 != m.rs2;
                    3'd4:    e_jmp.taken = $signed(m.rs1) < $signed(m.rs2);
                    3'd5:    e_jmp.taken = $signed(m.rs1) >= $signed(m.rs2);
                    3'd6:    e_jmp.taken = m.rs1 < m.rs2;
                    default: e_jmp.taken = m.rs1 >= m.rs2;
                endcase
            end
        endcase
    endtask

    function automatic logic [31:0] pick_operand();
        logic [31:0] edges [0:5] = '{32'h0, 32'd31, 32'h7fff_ffff, 32'h8000_0000,
                                      32'hffff_ffff, 32'hffff_f800};
        if ($urandom_range(0, 3) == 0) begin
            return edges[$urandom_range(0, 5)];
        end
        return $urandom;
    endfunction

    task automatic drive_random();
        logic [6:0]  maj;
        logic [6:0]  f7;
        logic [31:0] a;
        int          r;
        r   = $urandom_range(0, 9);
        maj = (r == 9) ? 7'($urandom) : majors[r];     // some unknown majors
        r   = $urandom_range(0, 9);
        f7  = (r < 7) ? `FUNCT7_BASE : ((r < 9) ? `FUNCT7_ALT : 7'($urandom));
        a   = pick_operand();
        opcode   <= {maj, 3'($urandom), f7};
        rs1_data <= a;
        rs2_data <= ($urandom_range(0, 3) == 0) ? a : pick_operand();
        imm      <= pick_operand();
        pc       <= 32'($urandom) & ~32'h3;
        rd_addr  <= 5'($urandom);
        allow    <= $urandom_range(0, 9) != 0;
        stall    <= $urandom_range(0, 9) == 0;
        flush    <= $urandom_range(0, 19) == 0;
        mmu_wait <= $urandom_range(0, 6) == 0;
    endtask

    task automatic report_mismatch(string name, logic [68:0] exp_v, logic [68:0] act_v);
        errors++;
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    endtask

    // model register with the stage's priority
    always @(posedge CLK) begin
        if (!rst_n || flush) begin
            m = '0;
        end else if (mmu_wait) begin
            m = m;
        end else if (stall || !allow) begin
            m = '0;
        end else begin
            m = '{valid: 1'b1, pc: pc, opc: opcode, rd: rd_addr, rs1: rs1_data,
                  rs2: rs2_data, imm: imm};
        end
        checking = 1'b1;
    end

    always @(negedge CLK) begin
        if (checking) begin
            model_outputs();
            checks++;
            if (valid !== m.valid) report_mismatch("valid", 69'(m.valid), 69'(valid));
            if (exec_pc !== m.pc) report_mismatch("exec_pc", 69'(m.pc), 69'(exec_pc));
            if (reg_wr !== e_reg) report_mismatch("reg_wr", 69'(e_reg), 69'(reg_wr));
            if (mem_rd !== e_rd) report_mismatch("mem_rd", 69'(e_rd), 69'(mem_rd));
            if (mem_wr !== e_wr) report_mismatch("mem_wr", 69'(e_wr), 69'(mem_wr));
            if (jump !== e_jmp) report_mismatch("jump", 69'(e_jmp), 69'(jump));
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout at %0t ns: the stimulus loop did not complete", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_n    = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        mmu_wait = 1'b0;
        allow    = 1'b0;
        pc       = '0;
        opcode   = '0;
        rd_addr  = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm      = '0;
        repeat (2) @(posedge CLK);
        rst_n <= 1'b1;
        repeat (NUM_CYCLES) begin
            @(posedge CLK);
            drive_random();
        end
        @(posedge CLK);
        $display("%0d cycles checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
exec_pkg.sv
exec_decode.sv
exec_pipe_reg.sv
exec_alu.sv
exec_branch.sv
exec_mem_req.sv
exec_stage.sv
exec_asserts.sv
tb_exec_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
